//--- hdl/id_pkg.sv
package id_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [5:0]  opcode_t;    // also carries the func field

    typedef enum logic [7:0] {
        ALU_NOP   = 8'b0000_0000,
        ALU_OR    = 8'b0010_0101,
        ALU_AND   = 8'b0010_0100,
        ALU_XOR   = 8'b0010_0110,
        ALU_NOR   = 8'b0010_0111,
        ALU_SLL   = 8'b0111_1100,
        ALU_SRL   = 8'b0000_0010,
        ALU_SRA   = 8'b0000_0011,
        ALU_SLT   = 8'b0010_1010,
        ALU_SLTU  = 8'b0010_1011,
        ALU_ADD   = 8'b0010_0000,
        ALU_ADDU  = 8'b0010_0001,
        ALU_SUB   = 8'b0010_0010,
        ALU_SUBU  = 8'b0010_0011,
        ALU_ADDI  = 8'b0101_0101,
        ALU_ADDIU = 8'b0101_0110,
        ALU_LB    = 8'b1110_0000,
        ALU_LBU   = 8'b1110_0100,
        ALU_LH    = 8'b1110_0001,
        ALU_LHU   = 8'b1110_0101,
        ALU_LW    = 8'b1110_0011
    } aluop_t;

    typedef enum logic [2:0] {
        SEL_NOP         = 3'b000,
        SEL_LOGIC       = 3'b001,
        SEL_SHIFT       = 3'b010,
        SEL_ARITH       = 3'b100,
        SEL_JUMP_BRANCH = 3'b110,
        SEL_LOAD_STORE  = 3'b111
    } alusel_t;

    typedef enum logic [2:0] {
        BR_NONE, BR_ALWAYS, BR_EQ, BR_NE, BR_GTZ, BR_LEZ, BR_LTZ, BR_GEZ
    } branch_kind_t;

    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_REGIMM  = 6'b000001;
    localparam opcode_t OP_J       = 6'b000010;
    localparam opcode_t OP_JAL     = 6'b000011;
    localparam opcode_t OP_BEQ     = 6'b000100;
    localparam opcode_t OP_BNE     = 6'b000101;
    localparam opcode_t OP_BLEZ    = 6'b000110;
    localparam opcode_t OP_BGTZ    = 6'b000111;
    localparam opcode_t OP_ADDI    = 6'b001000;
    localparam opcode_t OP_ADDIU   = 6'b001001;
    localparam opcode_t OP_SLTI    = 6'b001010;
    localparam opcode_t OP_SLTIU   = 6'b001011;
    localparam opcode_t OP_ANDI    = 6'b001100;
    localparam opcode_t OP_ORI     = 6'b001101;
    localparam opcode_t OP_XORI    = 6'b001110;
    localparam opcode_t OP_LUI     = 6'b001111;
    localparam opcode_t OP_LB      = 6'b100000;
    localparam opcode_t OP_LH      = 6'b100001;
    localparam opcode_t OP_LW      = 6'b100011;
    localparam opcode_t OP_LBU     = 6'b100100;
    localparam opcode_t OP_LHU     = 6'b100101;

    localparam opcode_t FN_SLL  = 6'b000000;
    localparam opcode_t FN_SRL  = 6'b000010;
    localparam opcode_t FN_SRA  = 6'b000011;
    localparam opcode_t FN_SLLV = 6'b000100;
    localparam opcode_t FN_SRLV = 6'b000110;
    localparam opcode_t FN_SRAV = 6'b000111;
    localparam opcode_t FN_JR   = 6'b001000;
    localparam opcode_t FN_JALR = 6'b001001;
    localparam opcode_t FN_ADD  = 6'b100000;
    localparam opcode_t FN_ADDU = 6'b100001;
    localparam opcode_t FN_SUB  = 6'b100010;
    localparam opcode_t FN_SUBU = 6'b100011;
    localparam opcode_t FN_AND  = 6'b100100;
    localparam opcode_t FN_OR   = 6'b100101;
    localparam opcode_t FN_XOR  = 6'b100110;
    localparam opcode_t FN_NOR  = 6'b100111;
    localparam opcode_t FN_SLT  = 6'b101010;
    localparam opcode_t FN_SLTU = 6'b101011;

    localparam logic [4:0] RI_BLTZ   = 5'b00000;
    localparam logic [4:0] RI_BGEZ   = 5'b00001;
    localparam logic [4:0] RI_BLTZAL = 5'b10000;
    localparam logic [4:0] RI_BGEZAL = 5'b10001;

    localparam reg_addr_t LINK_REG = 5'd31;
    localparam int NUM_READ_PORTS = 2;

    // result group of an execute op
    function automatic alusel_t alusel_of(aluop_t op);
        case (op)
            ALU_NOP:                            return SEL_NOP;
            ALU_OR, ALU_AND, ALU_XOR, ALU_NOR:  return SEL_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA:          return SEL_SHIFT;
            ALU_LB, ALU_LBU, ALU_LH, ALU_LHU,
            ALU_LW:                             return SEL_LOAD_STORE;
            default:                            return SEL_ARITH;
        endcase
    endfunction

endpackage

//--- hdl/operand_if.sv
`timescale 1ns/1ns

interface operand_if
    import id_pkg::*;
();

    logic      read_en;        // regfile read wanted
    reg_addr_t addr;           // register number
    word_t     imm;            // value when not read
    word_t     value;          // resolved operand
    logic      load_hazard;    // producer is a load still in ex

    modport dec (output read_en, output addr, output imm);

    modport fwd (
        input  read_en, input addr, input imm,
        output value, output load_hazard
    );

    // consumers of the resolved operand
    modport sink (input value, input load_hazard);

endinterface

//--- hdl/inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder
    import id_pkg::*;
(
    input  inst_t        inst_i,
    input  word_t        pc_i,
    operand_if.dec       op [NUM_READ_PORTS],
    output aluop_t       aluop_o,
    output alusel_t      alusel_o,
    output reg_addr_t    wd_o,
    output logic         wreg_o,
    output branch_kind_t branch_kind_o,
    output logic         branch_reg_target_o,
    output logic         link_o
);

    opcode_t    opcode;
    opcode_t    func;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic [4:0] shamt;
    aluop_t     fn_op;     // op of an R-type func
    aluop_t     im_op;     // op of an I-type opcode
    logic       sft_imm;   // sll/srl/sra take shamt
    logic [1:0] rd_en;     // bit 0 rs, bit 1 rt
    word_t      imm;

    assign opcode  = inst_i[31:26];
    assign rs      = inst_i[25:21];
    assign rt      = inst_i[20:16];
    assign rd      = inst_i[15:11];
    assign shamt   = inst_i[10:6];
    assign func    = inst_i[5:0];
    assign sft_imm = (func[5:2] == 4'b0000);

    always_comb begin
        case (func)
            FN_OR:            fn_op = ALU_OR;
            FN_AND:           fn_op = ALU_AND;
            FN_XOR:           fn_op = ALU_XOR;
            FN_NOR:           fn_op = ALU_NOR;
            FN_SLL, FN_SLLV:  fn_op = ALU_SLL;
            FN_SRL, FN_SRLV:  fn_op = ALU_SRL;
            FN_SRA, FN_SRAV:  fn_op = ALU_SRA;
            FN_SLT:           fn_op = ALU_SLT;
            FN_SLTU:          fn_op = ALU_SLTU;
            FN_ADD:           fn_op = ALU_ADD;
            FN_ADDU:          fn_op = ALU_ADDU;
            FN_SUB:           fn_op = ALU_SUB;
            FN_SUBU:          fn_op = ALU_SUBU;
            default:          fn_op = ALU_NOP;
        endcase
    end

    always_comb begin
        case (opcode)
            OP_ORI, OP_LUI:   im_op = ALU_OR;    // lui is or with upper imm
            OP_ANDI:          im_op = ALU_AND;
            OP_XORI:          im_op = ALU_XOR;
            OP_SLTI:          im_op = ALU_SLT;
            OP_SLTIU:         im_op = ALU_SLTU;
            OP_ADDI:          im_op = ALU_ADDI;
            OP_ADDIU:         im_op = ALU_ADDIU;
            OP_LB:            im_op = ALU_LB;
            OP_LBU:           im_op = ALU_LBU;
            OP_LH:            im_op = ALU_LH;
            OP_LHU:           im_op = ALU_LHU;
            OP_LW:            im_op = ALU_LW;
            default:          im_op = ALU_NOP;
        endcase
    end

    always_comb begin
        aluop_o             = ALU_NOP;
        wd_o                = rd;
        wreg_o              = 1'b0;
        rd_en               = 2'b00;
        imm                 = '0;
        branch_kind_o       = BR_NONE;
        branch_reg_target_o = 1'b0;
        link_o              = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                if (func == FN_JR || func == FN_JALR) begin
                    rd_en               = 2'b01;
                    branch_kind_o       = BR_ALWAYS;
                    branch_reg_target_o = 1'b1;
                    link_o              = func[0];    // jalr links to rd
                    wreg_o              = func[0];
                end else if (fn_op != ALU_NOP && (sft_imm ? rs == 5'd0 : shamt == 5'd0)) begin
                    aluop_o = fn_op;
                    wreg_o  = 1'b1;
                    rd_en   = sft_imm ? 2'b10 : 2'b11;
                    imm     = {27'd0, shamt};
                end
            end
            OP_REGIMM: begin
                rd_en = 2'b01;
                wd_o  = LINK_REG;
                case (rt)
                    RI_BLTZ, RI_BLTZAL: branch_kind_o = BR_LTZ;
                    RI_BGEZ, RI_BGEZAL: branch_kind_o = BR_GEZ;
                    default:            rd_en = 2'b00;
                endcase
                link_o = (branch_kind_o != BR_NONE) && rt[4];
                wreg_o = link_o;
            end
            OP_J, OP_JAL: begin
                branch_kind_o = BR_ALWAYS;
                wd_o          = LINK_REG;
                link_o        = opcode[0];
                wreg_o        = opcode[0];
            end
            OP_BEQ, OP_BNE: begin
                rd_en         = 2'b11;
                branch_kind_o = opcode[0] ? BR_NE : BR_EQ;
            end
            OP_BLEZ, OP_BGTZ: begin
                rd_en         = 2'b01;
                branch_kind_o = opcode[0] ? BR_GTZ : BR_LEZ;
            end
            default: begin
                if (im_op != ALU_NOP) begin
                    aluop_o = im_op;
                    wreg_o  = 1'b1;
                    wd_o    = rt;
                    rd_en   = 2'b01;
                    if (opcode == OP_LUI) begin
                        imm = {inst_i[15:0], 16'd0};
                    end else if (opcode[5:2] == 4'b0011) begin    // andi, ori, xori
                        imm = {16'd0, inst_i[15:0]};
                    end else begin
                        imm = {{16{inst_i[15]}}, inst_i[15:0]};
                    end
                end
            end
        endcase
    end

    assign alusel_o = link_o ? SEL_JUMP_BRANCH : alusel_of(aluop_o);

    assign op[0].read_en = rd_en[0];
    assign op[0].addr    = rs;
    assign op[0].imm     = imm;
    assign op[1].read_en = rd_en[1];
    assign op[1].addr    = rt;
    // link forms carry the return address as second operand
    assign op[1].imm     = link_o ? pc_i + 32'd8 : imm;

endmodule

//--- hdl/operand_forward.sv
`timescale 1ns/1ns

module operand_forward
    import id_pkg::*;
(
    operand_if.fwd op,
    input  word_t     reg_data_i,
    input  aluop_t    ex_aluop_i,
    input  logic      ex_wreg_i,
    input  reg_addr_t ex_wd_i,
    input  word_t     ex_wdata_i,
    input  logic      mem_wreg_i,
    input  reg_addr_t mem_wd_i,
    input  word_t     mem_wdata_i
);

    logic ex_is_load;
    logic ex_hit;
    logic mem_hit;

    // load data only exists after mem, so ex cannot forward it
    assign ex_is_load = (alusel_of(ex_aluop_i) == SEL_LOAD_STORE);
    assign ex_hit     = ex_wreg_i && (ex_wd_i == op.addr);
    assign mem_hit    = mem_wreg_i && (mem_wd_i == op.addr);

    assign op.load_hazard = op.read_en && ex_is_load && (ex_wd_i == op.addr);

    always_comb begin
        if (!op.read_en) begin
            op.value = op.imm;
        end else if (ex_hit) begin
            op.value = ex_wdata_i;     // youngest result wins
        end else if (mem_hit) begin
            op.value = mem_wdata_i;
        end else begin
            op.value = reg_data_i;
        end
    end

endmodule

//--- hdl/branch_resolver.sv
`timescale 1ns/1ns

module branch_resolver
    import id_pkg::*;
(
    operand_if.sink      op [NUM_READ_PORTS],
    input  word_t        pc_i,
    input  inst_t        inst_i,
    input  branch_kind_t branch_kind_i,
    input  logic         branch_reg_target_i,
    output logic         taken_o,
    output word_t        target_o,
    output word_t        link_addr_o
);

    word_t rs_val;
    word_t rt_val;
    word_t pc_plus4;
    word_t br_offset;
    logic  rs_zero;

    assign rs_val    = op[0].value;
    assign rt_val    = op[1].value;
    assign pc_plus4  = pc_i + 32'd4;
    assign br_offset = {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
    assign rs_zero   = (rs_val == '0);

    always_comb begin
        case (branch_kind_i)
            BR_ALWAYS: taken_o = 1'b1;
            BR_EQ:     taken_o = (rs_val == rt_val);
            BR_NE:     taken_o = (rs_val != rt_val);
            BR_GTZ:    taken_o = !rs_val[31] && !rs_zero;
            BR_LEZ:    taken_o = rs_val[31] || rs_zero;
            BR_LTZ:    taken_o = rs_val[31];
            BR_GEZ:    taken_o = !rs_val[31];
            default:   taken_o = 1'b0;
        endcase
    end

    always_comb begin
        if (!taken_o) begin
            target_o = '0;
        end else if (branch_reg_target_i) begin
            target_o = rs_val;                                  // jr, jalr
        end else if (branch_kind_i == BR_ALWAYS) begin
            target_o = {pc_plus4[31:28], inst_i[25:0], 2'b00};  // j, jal
        end else begin
            target_o = pc_plus4 + br_offset;
        end
    end

    assign link_addr_o = pc_i + 32'd8;    // skips the delay slot

endmodule

//--- hdl/id_ex_reg.sv
`timescale 1ns/1ns

module id_ex_reg
    import id_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n_i,
    operand_if.sink     op [NUM_READ_PORTS],
    input  aluop_t      aluop_i,
    input  alusel_t     alusel_i,
    input  reg_addr_t   wd_i,
    input  logic        wreg_i,
    input  logic        link_i,
    input  logic        taken_i,
    input  word_t       target_i,
    input  word_t       link_addr_i,
    input  inst_t       inst_i,
    output logic        stall_o,
    output aluop_t      aluop_o,
    output alusel_t     alusel_o,
    output word_t       reg1_o,
    output word_t       reg2_o,
    output reg_addr_t   wd_o,
    output logic        wreg_o,
    output word_t       link_addr_o,
    output logic        branch_flag_o,
    output word_t       branch_target_o,
    output logic        in_delayslot_o,
    output inst_t       inst_o
);

    logic next_in_slot;    // next accepted inst sits in a delay slot

    assign stall_o = op[0].load_hazard | op[1].load_hazard;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            aluop_o         <= ALU_NOP;
            alusel_o        <= SEL_NOP;
            reg1_o          <= '0;
            reg2_o          <= '0;
            wd_o            <= '0;
            wreg_o          <= 1'b0;
            link_addr_o     <= '0;
            branch_flag_o   <= 1'b0;
            branch_target_o <= '0;
            in_delayslot_o  <= 1'b0;
            inst_o          <= '0;
            next_in_slot    <= 1'b0;
        end else begin
            // a stall sends a bubble and keeps the inst in decode
            aluop_o         <= stall_o ? ALU_NOP : aluop_i;
            alusel_o        <= stall_o ? SEL_NOP : alusel_i;
            reg1_o          <= stall_o ? '0 : op[0].value;
            reg2_o          <= stall_o ? '0 : op[1].value;
            wd_o            <= stall_o ? '0 : wd_i;
            wreg_o          <= !stall_o && wreg_i;
            link_addr_o     <= (!stall_o && link_i) ? link_addr_i : '0;
            branch_flag_o   <= !stall_o && taken_i;
            branch_target_o <= stall_o ? '0 : target_i;
            in_delayslot_o  <= !stall_o && next_in_slot;
            inst_o          <= stall_o ? '0 : inst_i;
            if (!stall_o) begin
                next_in_slot <= taken_i;    // held across a stall
            end
        end
    end

    // fetch holds the stalled inst until the hazard clears
    assert property (@(posedge clk) disable iff (!arst_n_i)
        stall_o |=> $stable(inst_i))
        else $error("instruction changed while decode was stalled");

endmodule

//--- hdl/id_stage.sv
`timescale 1ns/1ns

module id_stage
    import id_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,
    input  word_t     pc_i,
    input  inst_t     inst_i,
    input  aluop_t    ex_aluop_i,
    input  logic      ex_wreg_i,
    input  reg_addr_t ex_wd_i,
    input  word_t     ex_wdata_i,
    input  logic      mem_wreg_i,
    input  reg_addr_t mem_wd_i,
    input  word_t     mem_wdata_i,
    input  word_t     reg1_data_i,
    input  word_t     reg2_data_i,
    output logic      reg1_read_o,
    output logic      reg2_read_o,
    output reg_addr_t reg1_addr_o,
    output reg_addr_t reg2_addr_o,
    output aluop_t    aluop_o,
    output alusel_t   alusel_o,
    output word_t     reg1_o,
    output word_t     reg2_o,
    output reg_addr_t wd_o,
    output logic      wreg_o,
    output word_t     link_addr_o,
    output logic      branch_flag_o,
    output word_t     branch_target_o,
    output logic      in_delayslot_o,
    output inst_t     inst_o,
    output logic      stall_o
);

    operand_if op_if [NUM_READ_PORTS] ();    // 0 rs, 1 rt

    aluop_t       dec_aluop;
    alusel_t      dec_alusel;
    reg_addr_t    dec_wd;
    logic         dec_wreg;
    branch_kind_t dec_kind;
    logic         dec_reg_target;
    logic         dec_link;
    logic         br_taken;
    word_t        br_target;
    word_t        br_link_addr;
    word_t        reg_data [NUM_READ_PORTS];

    assign reg_data[0] = reg1_data_i;
    assign reg_data[1] = reg2_data_i;

    // regfile reads go out in the same cycle
    assign reg1_read_o = op_if[0].read_en;
    assign reg1_addr_o = op_if[0].addr;
    assign reg2_read_o = op_if[1].read_en;
    assign reg2_addr_o = op_if[1].addr;

    inst_decoder i_inst_decoder (
        .inst_i              (inst_i),
        .pc_i                (pc_i),
        .op                  (op_if),
        .aluop_o             (dec_aluop),
        .alusel_o            (dec_alusel),
        .wd_o                (dec_wd),
        .wreg_o              (dec_wreg),
        .branch_kind_o       (dec_kind),
        .branch_reg_target_o (dec_reg_target),
        .link_o              (dec_link)
    );

    for (genvar g = 0; g < NUM_READ_PORTS; g++) begin : g_fwd
        operand_forward i_operand_forward (
            .op          (op_if[g]),
            .reg_data_i  (reg_data[g]),
            .ex_aluop_i  (ex_aluop_i),
            .ex_wreg_i   (ex_wreg_i),
            .ex_wd_i     (ex_wd_i),
            .ex_wdata_i  (ex_wdata_i),
            .mem_wreg_i  (mem_wreg_i),
            .mem_wd_i    (mem_wd_i),
            .mem_wdata_i (mem_wdata_i)
        );
    end

    branch_resolver i_branch_resolver (
        .op                  (op_if),
        .pc_i                (pc_i),
        .inst_i              (inst_i),
        .branch_kind_i       (dec_kind),
        .branch_reg_target_i (dec_reg_target),
        .taken_o             (br_taken),
        .target_o            (br_target),
        .link_addr_o         (br_link_addr)
    );

    id_ex_reg i_id_ex_reg (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .op              (op_if),
        .aluop_i         (dec_aluop),
        .alusel_i        (dec_alusel),
        .wd_i            (dec_wd),
        .wreg_i          (dec_wreg),
        .link_i          (dec_link),
        .taken_i         (br_taken),
        .target_i        (br_target),
        .link_addr_i     (br_link_addr),
        .inst_i          (inst_i),
        .stall_o         (stall_o),
        .aluop_o         (aluop_o),
        .alusel_o        (alusel_o),
        .reg1_o          (reg1_o),
        .reg2_o          (reg2_o),
        .wd_o            (wd_o),
        .wreg_o          (wreg_o),
        .link_addr_o     (link_addr_o),
        .branch_flag_o   (branch_flag_o),
        .branch_target_o (branch_target_o),
        .in_delayslot_o  (in_delayslot_o),
        .inst_o          (inst_o)
    );

endmodule

//--- sim/id_tb_tasks.svh
`ifndef ID_TB_TASKS_SVH
`define ID_TB_TASKS_SVH

function automatic inst_t r_form(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                                 logic [4:0] sa, opcode_t fn);
    return {OP_SPECIAL, rs, rt, rd, sa, fn};
endfunction

function automatic inst_t i_form(opcode_t opc, reg_addr_t rs, reg_addr_t rt,
                                 logic [15:0] imm);
    return {opc, rs, rt, imm};
endfunction

function automatic inst_t j_form(opcode_t opc, logic [25:0] idx);
    return {opc, idx};
endfunction

// sign-extended word offset added to pc+4
function automatic word_t branch_dest(word_t bpc, logic [15:0] off);
    return bpc + 32'd4 + {{14{off[15]}}, off, 2'b00};
endfunction

task automatic next_edge();
    @(posedge clk);
    #2;    // drive and sample point
endtask

task automatic compare(string name, logic [31:0] expected, logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("FAIL at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
endtask

// drive one instruction and let it pass the register
task automatic present(word_t pc_v, inst_t inst_v);
    pc   = pc_v;
    inst = inst_v;
    next_edge();
endtask

// regfile read requests of the instruction still on inst_i
task automatic check_reads(logic e1, logic e2, reg_addr_t a1, reg_addr_t a2);
    compare("reg1_read_o", e1, reg1_read);
    compare("reg2_read_o", e2, reg2_read);
    compare("reg1_addr_o", a1, reg1_addr);
    compare("reg2_addr_o", a2, reg2_addr);
endtask

task automatic check_bubble();
    compare("aluop_o", ALU_NOP, aluop);
    compare("alusel_o", SEL_NOP, alusel);
    compare("reg1_o", '0, reg1);
    compare("reg2_o", '0, reg2);
    compare("wd_o", '0, wd);
    compare("wreg_o", 1'b0, wreg);
    compare("link_addr_o", '0, link_addr);
    compare("branch_flag_o", 1'b0, branch_flag);
    compare("branch_target_o", '0, branch_target);
    compare("in_delayslot_o", 1'b0, in_delayslot);
    compare("inst_o", '0, inst_out);
endtask

task automatic check_fields(aluop_t eop, alusel_t esel, reg_addr_t ewd, logic ewreg,
                            word_t e1, word_t e2);
    compare("aluop_o", eop, aluop);
    compare("alusel_o", esel, alusel);
    compare("wd_o", ewd, wd);
    compare("wreg_o", ewreg, wreg);
    compare("reg1_o", e1, reg1);
    compare("reg2_o", e2, reg2);
    compare("inst_o", inst, inst_out);
endtask

task automatic reset_and_unknown();
    int c;
    arst_n = 1'b0;
    inst   = i_form(OP_ORI, 5'd3, 5'd7, 16'h1234);    // held off by reset
    for (c = 0; c < 3; c++) begin
        next_edge();
        check_bubble();
    end
    inst   = r_form(5'd3, 5'd7, 5'd12, 5'd0, 6'b011000);    // mult
    arst_n = 1'b1;
    check_bubble();
    next_edge();
    compare("aluop_o", ALU_NOP, aluop);
    compare("alusel_o", SEL_NOP, alusel);
    compare("wreg_o", 1'b0, wreg);
    present(32'h0000_0100, i_form(6'b111111, 5'd3, 5'd7, 16'hffff));
    compare("aluop_o", ALU_NOP, aluop);
    compare("alusel_o", SEL_NOP, alusel);
    compare("wreg_o", 1'b0, wreg);
    compare("branch_flag_o", 1'b0, branch_flag);
endtask

task automatic decode_alu_ops();
    logic [15:0] imm;
    logic [4:0]  sa;
    word_t       apc;
    apc = 32'h0040_0000;
    present(apc, r_form(5'd3, 5'd7, 5'd12, 5'd0, FN_OR));
    check_fields(ALU_OR, SEL_LOGIC, 5'd12, 1'b1, reg_model(5'd3), reg_model(5'd7));
    check_reads(1'b1, 1'b1, 5'd3, 5'd7);
    present(apc + 4, r_form(5'd3, 5'd7, 5'd12, 5'd0, FN_ADDU));
    check_fields(ALU_ADDU, SEL_ARITH, 5'd12, 1'b1, reg_model(5'd3), reg_model(5'd7));
    check_reads(1'b1, 1'b1, 5'd3, 5'd7);
    present(apc + 8, r_form(5'd3, 5'd7, 5'd12, 5'd0, FN_SUB));
    check_fields(ALU_SUB, SEL_ARITH, 5'd12, 1'b1, reg_model(5'd3), reg_model(5'd7));
    check_reads(1'b1, 1'b1, 5'd3, 5'd7);
    sa = 5'($random(seed));
    present(apc + 12, r_form(5'd0, 5'd7, 5'd12, sa, FN_SLL));
    // shift amount rides in on the rs operand
    check_fields(ALU_SLL, SEL_SHIFT, 5'd12, 1'b1, {27'd0, sa}, reg_model(5'd7));
    check_reads(1'b0, 1'b1, 5'd0, 5'd7);
    imm = 16'($random(seed));
    present(apc + 16, i_form(OP_ORI, 5'd3, 5'd7, imm));
    check_fields(ALU_OR, SEL_LOGIC, 5'd7, 1'b1, reg_model(5'd3), {16'd0, imm});
    check_reads(1'b1, 1'b0, 5'd3, 5'd7);
    imm = 16'($random(seed));
    present(apc + 20, i_form(OP_ANDI, 5'd3, 5'd7, imm));
    check_fields(ALU_AND, SEL_LOGIC, 5'd7, 1'b1, reg_model(5'd3), {16'd0, imm});
    check_reads(1'b1, 1'b0, 5'd3, 5'd7);
    imm = 16'($random(seed));
    present(apc + 24, i_form(OP_LUI, 5'd0, 5'd7, imm));
    check_fields(ALU_OR, SEL_LOGIC, 5'd7, 1'b1, '0, {imm, 16'd0});
    check_reads(1'b1, 1'b0, 5'd0, 5'd7);
    imm = 16'($random(seed));
    present(apc + 28, i_form(OP_SLTI, 5'd3, 5'd7, imm));
    check_fields(ALU_SLT, SEL_ARITH, 5'd7, 1'b1, reg_model(5'd3), {{16{imm[15]}}, imm});
    check_reads(1'b1, 1'b0, 5'd3, 5'd7);
    imm = 16'($random(seed));
    present(apc + 32, i_form(OP_ADDI, 5'd3, 5'd7, imm));
    check_fields(ALU_ADDI, SEL_ARITH, 5'd7, 1'b1, reg_model(5'd3), {{16{imm[15]}}, imm});
    check_reads(1'b1, 1'b0, 5'd3, 5'd7);
endtask

task automatic forwarding_priority();
    word_t ex_val;
    word_t mem_val;
    inst_t fwd_inst;
    ex_val    = $random(seed);
    mem_val   = $random(seed);
    fwd_inst  = r_form(5'd5, 5'd6, 5'd12, 5'd0, FN_ADDU);
    ex_aluop  = ALU_ADDU;
    ex_wreg   = 1'b1;
    ex_wd     = 5'd5;
    ex_wdata  = ex_val;
    mem_wreg  = 1'b1;
    mem_wd    = 5'd5;
    mem_wdata = mem_val;
    present(32'h0040_0200, fwd_inst);
    compare("reg1_o", ex_val, reg1);    // ex beats mem
    compare("reg2_o", reg_model(5'd6), reg2);
    ex_wreg = 1'b0;
    present(32'h0040_0204, fwd_inst);
    compare("reg1_o", mem_val, reg1);
    mem_wreg = 1'b0;
    present(32'h0040_0208, fwd_inst);
    compare("reg1_o", reg_model(5'd5), reg1);
    ex_aluop = ALU_NOP;
    ex_wd    = '0;
    mem_wd   = '0;
endtask

task automatic load_use_stall();
    int n;
    ex_aluop = ALU_LW;
    ex_wreg  = 1'b1;
    ex_wd    = 5'd8;
    ex_wdata = 32'hdead_beef;
    pc       = 32'h0040_0300;
    inst     = r_form(5'd4, 5'd8, 5'd9, 5'd0, FN_ADDU);    // rt is the load target
    #1;
    compare("stall_o", 1'b1, stall);
    next_edge();
    check_bubble();
    ex_aluop = ALU_NOP;
    ex_wreg  = 1'b0;
    ex_wd    = '0;
    n = 0;
    #1;
    while (stall !== 1'b0 && n < STALL_TIMEOUT) begin
        @(posedge clk);
        #1;
        n++;
    end
    if (stall !== 1'b0) begin
        errors++;
        $display("timeout: stall_o still high after %0d cycles", STALL_TIMEOUT);
    end
    next_edge();
    check_fields(ALU_ADDU, SEL_ARITH, 5'd9, 1'b1, reg_model(5'd4), reg_model(5'd8));
endtask

task automatic branch_and_jump();
    word_t       bpc;
    word_t       pc4;
    logic [15:0] off;
    logic [25:0] idx;
    bpc = 32'hb000_0200;    // upper nibble shows the region
    pc4 = bpc + 32'd4;
    off = 16'($random(seed));
    present(bpc, i_form(OP_BEQ, 5'd5, 5'd5, off));
    compare("branch_flag_o", 1'b1, branch_flag);
    compare("branch_target_o", branch_dest(bpc, off), branch_target);
    compare("wreg_o", 1'b0, wreg);
    present(bpc, i_form(OP_BEQ, 5'd5, 5'd6, off));
    compare("branch_flag_o", 1'b0, branch_flag);
    ex_aluop = ALU_ADDU;
    ex_wreg  = 1'b1;
    ex_wd    = 5'd10;
    ex_wdata = 32'h8000_0000 | $random(seed);    // negative value from ex
    present(bpc, i_form(OP_REGIMM, 5'd10, RI_BLTZ, off));
    compare("branch_flag_o", 1'b1, branch_flag);
    compare("branch_target_o", branch_dest(bpc, off), branch_target);
    ex_aluop = ALU_NOP;
    ex_wreg  = 1'b0;
    ex_wd    = '0;
    idx = 26'($random(seed));
    present(bpc, j_form(OP_J, idx));
    compare("branch_flag_o", 1'b1, branch_flag);
    compare("branch_target_o", {pc4[31:28], idx, 2'b00}, branch_target);
    compare("wreg_o", 1'b0, wreg);
    present(bpc, j_form(OP_JAL, idx));
    compare("branch_flag_o", 1'b1, branch_flag);
    compare("branch_target_o", {pc4[31:28], idx, 2'b00}, branch_target);
    compare("alusel_o", SEL_JUMP_BRANCH, alusel);
    compare("wd_o", 5'd31, wd);
    compare("wreg_o", 1'b1, wreg);
    compare("link_addr_o", bpc + 32'd8, link_addr);
    present(bpc, r_form(5'd13, 5'd0, 5'd0, 5'd0, FN_JR));
    compare("branch_flag_o", 1'b1, branch_flag);
    compare("branch_target_o", reg_model(5'd13), branch_target);
    compare("wreg_o", 1'b0, wreg);
    check_reads(1'b1, 1'b0, 5'd13, 5'd0);
endtask

task automatic delay_slot_flag();
    word_t dpc;
    inst_t plain;
    dpc   = 32'h0040_1000;
    plain = r_form(5'd1, 5'd2, 5'd3, 5'd0, FN_ADDU);
    present(dpc - 4, plain);    // fills the slot behind the jr
    present(dpc, plain);
    compare("in_delayslot_o", 1'b0, in_delayslot);
    present(dpc + 4, i_form(OP_BEQ, 5'd5, 5'd5, 16'h0010));    // taken
    compare("branch_flag_o", 1'b1, branch_flag);
    compare("in_delayslot_o", 1'b0, in_delayslot);
    present(dpc + 8, plain);
    compare("in_delayslot_o", 1'b1, in_delayslot);
    compare("branch_flag_o", 1'b0, branch_flag);
    present(dpc + 12, i_form(OP_ORI, 5'd1, 5'd4, 16'h00ff));
    compare("in_delayslot_o", 1'b0, in_delayslot);
    present(dpc + 16, i_form(OP_BEQ, 5'd5, 5'd6, 16'h0010));    // not taken
    compare("branch_flag_o", 1'b0, branch_flag);
    compare("in_delayslot_o", 1'b0, in_delayslot);
    present(dpc + 20, plain);
    compare("in_delayslot_o", 1'b0, in_delayslot);
endtask

`endif

//--- sim/tb_id_stage.sv
`timescale 1ns/1ns

module tb_id_stage
    import id_pkg::*;
();

    localparam int STALL_TIMEOUT = 8;    // cycles

    logic      clk;
    logic      arst_n;
    word_t     pc;
    inst_t     inst;
    aluop_t    ex_aluop;
    logic      ex_wreg;
    reg_addr_t ex_wd;
    word_t     ex_wdata;
    logic      mem_wreg;
    reg_addr_t mem_wd;
    word_t     mem_wdata;
    word_t     reg1_data;
    word_t     reg2_data;
    logic      reg1_read;
    logic      reg2_read;
    reg_addr_t reg1_addr;
    reg_addr_t reg2_addr;
    aluop_t    aluop;
    alusel_t   alusel;
    word_t     reg1;
    word_t     reg2;
    reg_addr_t wd;
    logic      wreg;
    word_t     link_addr;
    logic      branch_flag;
    word_t     branch_target;
    logic      in_delayslot;
    inst_t     inst_out;
    logic      stall;

    int        errors;
    int        checks;
    integer    seed;

    // register file model, each register holds its number in every byte
    function automatic word_t reg_model(reg_addr_t a);
        return 32'(a) * 32'h0101_0101;
    endfunction

    assign reg1_data = reg_model(reg1_addr);    // same-cycle read
    assign reg2_data = reg_model(reg2_addr);

    id_stage i_id_stage (
        .clk             (clk),
        .arst_n_i        (arst_n),
        .pc_i            (pc),
        .inst_i          (inst),
        .ex_aluop_i      (ex_aluop),
        .ex_wreg_i       (ex_wreg),
        .ex_wd_i         (ex_wd),
        .ex_wdata_i      (ex_wdata),
        .mem_wreg_i      (mem_wreg),
        .mem_wd_i        (mem_wd),
        .mem_wdata_i     (mem_wdata),
        .reg1_data_i     (reg1_data),
        .reg2_data_i     (reg2_data),
        .reg1_read_o     (reg1_read),
        .reg2_read_o     (reg2_read),
        .reg1_addr_o     (reg1_addr),
        .reg2_addr_o     (reg2_addr),
        .aluop_o         (aluop),
        .alusel_o        (alusel),
        .reg1_o          (reg1),
        .reg2_o          (reg2),
        .wd_o            (wd),
        .wreg_o          (wreg),
        .link_addr_o     (link_addr),
        .branch_flag_o   (branch_flag),
        .branch_target_o (branch_target),
        .in_delayslot_o  (in_delayslot),
        .inst_o          (inst_out),
        .stall_o         (stall)
    );

    `include "id_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;    // 40 ns period
    end

    initial begin
        errors    = 0;
        checks    = 0;
        seed      = 32'h5838bcd2;
        arst_n    = 1'b0;
        pc        = '0;
        inst      = '0;
        ex_aluop  = ALU_NOP;
        ex_wreg   = 1'b0;
        ex_wd     = '0;
        ex_wdata  = '0;
        mem_wreg  = 1'b0;
        mem_wd    = '0;
        mem_wdata = '0;

        reset_and_unknown();
        decode_alu_ops();
        forwarding_priority();
        load_use_stall();
        branch_and_jump();
        delay_slot_flag();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+sim
hdl/id_pkg.sv
hdl/operand_if.sv
hdl/inst_decoder.sv
hdl/operand_forward.sv
hdl/branch_resolver.sv
hdl/id_ex_reg.sv
hdl/id_stage.sv
sim/tb_id_stage.sv

//--- Bender.yml
package:
  name: id_stage

sources:
  - files:
      - hdl/id_pkg.sv
      - hdl/operand_if.sv
      - hdl/inst_decoder.sv
      - hdl/operand_forward.sv
      - hdl/branch_resolver.sv
      - hdl/id_ex_reg.sv
      - hdl/id_stage.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_id_stage.sv
